// File: common/ib_pkg.sv
package ib_pkg;

  // ====================
  // Geometry
  // ====================
  localparam int WORDS_PER_LINE = 4;
  localparam int DISP_SIZE      = 3;   // Default dispatch width
  localparam int LINE_DEPTH     = 4;   // Default queue depth

  typedef logic [WORDS_PER_LINE*32-1:0]        line_data_t;
  typedef logic [WORDS_PER_LINE-1:0]           word_en_t;
  typedef logic [$clog2(WORDS_PER_LINE)-1:0]   word_idx_t;
  typedef logic [31:0]                         pc_t;
  typedef logic [31:0]                         inst_t;
  typedef logic [$clog2(DISP_SIZE+1)-1:0]      disp_cnt_t;

  // Instruction classes seen by dispatch
  typedef enum logic [2:0] {
    CAT_ARITH,
    CAT_LD,
    CAT_ST,
    CAT_BR,
    CAT_CSU,
    CAT_ILLEGAL
  } inst_cat_t;

  // ====================
  // Issue limits
  // ====================
  // Per group, counted from slot 0
  localparam disp_cnt_t ARITH_LIMIT   = 2'd2;
  localparam disp_cnt_t MEM_LIMIT     = 2'd1;  // Loads and stores together
  localparam disp_cnt_t BR_LIMIT      = 2'd1;
  localparam disp_cnt_t CSU_LIMIT     = 2'd1;
  localparam disp_cnt_t ILLEGAL_LIMIT = 2'd1;

endpackage

// File: common/ib_window_if.sv
`timescale 1ns/100ps

interface ib_window_if #(
  parameter int DISP_SIZE = ib_pkg::DISP_SIZE
);
  import ib_pkg::*;

  logic [DISP_SIZE-1:0] slot_valid;
  inst_t                slot_inst [DISP_SIZE];
  pc_t                  slot_pc   [DISP_SIZE];  // Byte address of each slot
  inst_cat_t            slot_cat  [DISP_SIZE];

  modport builder (
    output slot_valid, slot_inst, slot_pc, slot_cat
  );

  modport picker (
    input slot_valid, slot_inst, slot_pc, slot_cat
  );

endinterface

// File: design/ib_top.sv
`timescale 1ns/100ps

module ib_top #(
  parameter int LINE_DEPTH = ib_pkg::LINE_DEPTH,
  parameter int DISP_SIZE  = ib_pkg::DISP_SIZE
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush_valid,

  // Fetch side
  input  logic                  i_inst_valid,
  output logic                  o_inst_ready,
  input  ib_pkg::pc_t           i_inst_pc,
  input  ib_pkg::line_data_t    i_inst_in,
  input  ib_pkg::word_en_t      i_inst_en,

  // Dispatch side
  output logic                  o_disp_valid,
  input  logic                  i_disp_ready,
  output logic [DISP_SIZE-1:0]  o_disp_mask,
  output ib_pkg::inst_t         o_disp_inst [DISP_SIZE],
  output ib_pkg::pc_t           o_disp_pc   [DISP_SIZE],
  output ib_pkg::inst_cat_t     o_disp_cat  [DISP_SIZE],
  output logic                  o_disp_has_br,
  output ib_pkg::disp_cnt_t     o_ld_cnt,
  output ib_pkg::disp_cnt_t     o_st_cnt
);
  import ib_pkg::*;

  localparam int PTR_W = $clog2(LINE_DEPTH);

  logic             w_wr_en;
  logic [PTR_W-1:0] w_wr_ptr;
  logic [PTR_W-1:0] w_head_ptr;
  logic [PTR_W-1:0] w_next_ptr;
  logic             w_head_held;
  logic             w_next_held;
  word_idx_t        w_cursor;
  word_idx_t        w_head_offset;
  logic             w_disp_fire;
  disp_cnt_t        w_adv_cnt;

  line_data_t       w_head_data;
  line_data_t       w_next_data;
  pc_t              w_head_pc;
  pc_t              w_next_pc;
  word_en_t         w_head_en;
  word_en_t         w_next_en;

  ib_window_if #(.DISP_SIZE(DISP_SIZE)) win_if ();

  // ====================
  // Line queue
  // ====================
  ib_queue_ctrl #(.LINE_DEPTH(LINE_DEPTH)) u_queue_ctrl (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_flush_valid (i_flush_valid),
    .i_inst_valid  (i_inst_valid),
    .i_disp_fire   (w_disp_fire),
    .i_adv_cnt     (w_adv_cnt),
    .i_head_offset (w_head_offset),
    .o_inst_ready  (o_inst_ready),
    .o_wr_en       (w_wr_en),
    .o_wr_ptr      (w_wr_ptr),
    .o_head_ptr    (w_head_ptr),
    .o_next_ptr    (w_next_ptr),
    .o_head_held   (w_head_held),
    .o_next_held   (w_next_held),
    .o_cursor      (w_cursor)
  );

  ib_line_store #(.LINE_DEPTH(LINE_DEPTH)) u_line_store (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_wr_en     (w_wr_en),
    .i_wr_ptr    (w_wr_ptr),
    .i_head_ptr  (w_head_ptr),
    .i_next_ptr  (w_next_ptr),
    .i_line_data (i_inst_in),
    .i_line_pc   (i_inst_pc),
    .i_line_en   (i_inst_en),
    .o_head_data (w_head_data),
    .o_next_data (w_next_data),
    .o_head_pc   (w_head_pc),
    .o_next_pc   (w_next_pc),
    .o_head_en   (w_head_en),
    .o_next_en   (w_next_en)
  );

  // ====================
  // Dispatch
  // ====================
  ib_window #(.DISP_SIZE(DISP_SIZE)) u_window (
    .i_head_data   (w_head_data),
    .i_next_data   (w_next_data),
    .i_head_pc     (w_head_pc),
    .i_next_pc     (w_next_pc),
    .i_head_en     (w_head_en),
    .i_next_en     (w_next_en),
    .i_head_held   (w_head_held),
    .i_next_held   (w_next_held),
    .i_cursor      (w_cursor),
    .o_head_offset (w_head_offset),
    .win           (win_if.builder)
  );

  ib_group_pick #(.DISP_SIZE(DISP_SIZE)) u_group_pick (
    .i_flush_valid (i_flush_valid),
    .i_disp_ready  (i_disp_ready),
    .win           (win_if.picker),
    .o_disp_valid  (o_disp_valid),
    .o_disp_mask   (o_disp_mask),
    .o_disp_inst   (o_disp_inst),
    .o_disp_pc     (o_disp_pc),
    .o_disp_cat    (o_disp_cat),
    .o_disp_has_br (o_disp_has_br),
    .o_ld_cnt      (o_ld_cnt),
    .o_st_cnt      (o_st_cnt),
    .o_disp_fire   (w_disp_fire),
    .o_adv_cnt     (w_adv_cnt)
  );

endmodule

// File: dispatch/ib_group_pick.sv
`timescale 1ns/100ps

module ib_group_pick #(
  parameter int DISP_SIZE = ib_pkg::DISP_SIZE
) (
  input  logic                 i_flush_valid,
  input  logic                 i_disp_ready,
  ib_window_if.picker          win,
  output logic                 o_disp_valid,
  output logic [DISP_SIZE-1:0] o_disp_mask,
  output ib_pkg::inst_t        o_disp_inst [DISP_SIZE],
  output ib_pkg::pc_t          o_disp_pc   [DISP_SIZE],
  output ib_pkg::inst_cat_t    o_disp_cat  [DISP_SIZE],
  output logic                 o_disp_has_br,
  output ib_pkg::disp_cnt_t    o_ld_cnt,
  output ib_pkg::disp_cnt_t    o_st_cnt,
  output logic                 o_disp_fire,
  output ib_pkg::disp_cnt_t    o_adv_cnt
);
  import ib_pkg::*;

  // ====================
  // Prefix under limits
  // ====================
  always_comb begin
    disp_cnt_t arith_n;
    disp_cnt_t mem_n;
    disp_cnt_t br_n;
    disp_cnt_t csu_n;
    disp_cnt_t ill_n;
    logic      run;
    logic      fits;

    arith_n = '0;
    mem_n   = '0;
    br_n    = '0;
    csu_n   = '0;
    ill_n   = '0;
    run     = 1'b1;
    for (int k = 0; k < DISP_SIZE; k++) begin
      case (win.slot_cat[k])
        CAT_ARITH:      fits = (arith_n < ARITH_LIMIT);
        CAT_LD, CAT_ST: fits = (mem_n < MEM_LIMIT);
        CAT_BR:         fits = (br_n < BR_LIMIT);
        CAT_CSU:        fits = (csu_n < CSU_LIMIT);
        default:        fits = (ill_n < ILLEGAL_LIMIT);
      endcase
      run = run & win.slot_valid[k] & fits;  // First miss ends the group
      o_disp_mask[k] = run;
      if (run) begin
        case (win.slot_cat[k])
          CAT_ARITH:      arith_n = arith_n + 1'b1;
          CAT_LD, CAT_ST: mem_n   = mem_n + 1'b1;
          CAT_BR:         br_n    = br_n + 1'b1;
          CAT_CSU:        csu_n   = csu_n + 1'b1;
          default:        ill_n   = ill_n + 1'b1;
        endcase
      end
    end
  end

  // Group contents and counts
  always_comb begin
    o_adv_cnt     = '0;
    o_ld_cnt      = '0;
    o_st_cnt      = '0;
    o_disp_has_br = 1'b0;
    for (int k = 0; k < DISP_SIZE; k++) begin
      if (o_disp_mask[k]) begin
        o_disp_inst[k] = win.slot_inst[k];
        o_disp_pc[k]   = win.slot_pc[k];
        o_disp_cat[k]  = win.slot_cat[k];
        o_adv_cnt      = o_adv_cnt + 1'b1;
        if (win.slot_cat[k] == CAT_LD) o_ld_cnt = o_ld_cnt + 1'b1;
        if (win.slot_cat[k] == CAT_ST) o_st_cnt = o_st_cnt + 1'b1;
        if (win.slot_cat[k] == CAT_BR) o_disp_has_br = 1'b1;
      end else begin
        o_disp_inst[k] = '0;
        o_disp_pc[k]   = '0;
        o_disp_cat[k]  = CAT_ARITH;
      end
    end
  end

  assign o_disp_valid = o_disp_mask[0] & ~i_flush_valid;
  assign o_disp_fire  = o_disp_valid & i_disp_ready;

endmodule

// File: dispatch/ib_window.sv
`timescale 1ns/100ps

module ib_window #(
  parameter int DISP_SIZE = ib_pkg::DISP_SIZE
) (
  input  ib_pkg::line_data_t i_head_data,
  input  ib_pkg::line_data_t i_next_data,
  input  ib_pkg::pc_t        i_head_pc,
  input  ib_pkg::pc_t        i_next_pc,
  input  ib_pkg::word_en_t   i_head_en,
  input  ib_pkg::word_en_t   i_next_en,
  input  logic               i_head_held,
  input  logic               i_next_held,
  input  ib_pkg::word_idx_t  i_cursor,
  output ib_pkg::word_idx_t  o_head_offset,
  ib_window_if.builder       win
);
  import ib_pkg::*;

  localparam int WORD_W   = $bits(word_idx_t);
  localparam int POS_W    = WORD_W + 1;   // MSB marks the next line
  localparam int LINE_B_W = WORD_W + 2;   // Byte offset bits of a line
  localparam int INST_W   = $bits(inst_t);

  word_idx_t w_start;

  function automatic inst_cat_t classify(input inst_t inst);
    case (inst[6:0])
      7'b0110011, 7'b0010011,
      7'b0110111, 7'b0010111: classify = CAT_ARITH;    // OP, OP-IMM, LUI, AUIPC
      7'b0000011:             classify = CAT_LD;
      7'b0100011:             classify = CAT_ST;
      7'b1100011, 7'b1101111,
      7'b1100111:             classify = CAT_BR;       // BRANCH, JAL, JALR
      7'b1110011:             classify = CAT_CSU;      // SYSTEM
      default:                classify = CAT_ILLEGAL;
    endcase
  endfunction

  assign o_head_offset = i_head_pc[LINE_B_W-1:2];
  assign w_start       = (o_head_offset > i_cursor) ? o_head_offset : i_cursor;

  // ====================
  // Slot extraction
  // ====================
  for (genvar k = 0; k < DISP_SIZE; k++) begin : g_slot
    logic [POS_W-1:0] w_pos;
    logic             w_in_next;
    word_idx_t        w_word;
    pc_t              w_base;
    inst_t            w_inst;

    assign w_pos     = POS_W'(w_start) + POS_W'(k);
    assign w_in_next = w_pos[POS_W-1];
    assign w_word    = w_pos[WORD_W-1:0];
    assign w_base    = w_in_next ? i_next_pc : i_head_pc;

    assign w_inst = w_in_next ? i_next_data[INST_W*w_word +: INST_W]
                              : i_head_data[INST_W*w_word +: INST_W];

    // Word must be held and enabled
    assign win.slot_valid[k] = w_in_next ? (i_next_held & i_next_en[w_word])
                                         : (i_head_held & i_head_en[w_word]);
    assign win.slot_inst[k]  = w_inst;
    assign win.slot_pc[k]    = {w_base[$bits(pc_t)-1:LINE_B_W], w_word, 2'b00};
    assign win.slot_cat[k]   = classify(w_inst);
  end

endmodule

// File: list.f
common/ib_pkg.sv
common/ib_window_if.sv
queue/ib_queue_ctrl.sv
queue/ib_line_store.sv
dispatch/ib_window.sv
dispatch/ib_group_pick.sv
design/ib_top.sv
verif/ib_properties.sv
verif/tb_ib.sv

// File: queue/ib_line_store.sv
`timescale 1ns/100ps

module ib_line_store #(
  parameter int LINE_DEPTH = ib_pkg::LINE_DEPTH
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_wr_en,
  input  logic [$clog2(LINE_DEPTH)-1:0] i_wr_ptr,
  input  logic [$clog2(LINE_DEPTH)-1:0] i_head_ptr,
  input  logic [$clog2(LINE_DEPTH)-1:0] i_next_ptr,
  input  ib_pkg::line_data_t            i_line_data,
  input  ib_pkg::pc_t                   i_line_pc,
  input  ib_pkg::word_en_t              i_line_en,
  output ib_pkg::line_data_t            o_head_data,
  output ib_pkg::line_data_t            o_next_data,
  output ib_pkg::pc_t                   o_head_pc,
  output ib_pkg::pc_t                   o_next_pc,
  output ib_pkg::word_en_t              o_head_en,
  output ib_pkg::word_en_t              o_next_en
);
  import ib_pkg::*;

  line_data_t r_data [LINE_DEPTH];
  pc_t        r_pc   [LINE_DEPTH];
  word_en_t   r_en   [LINE_DEPTH];

  // Line payload
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      r_data[i_wr_ptr] <= i_line_data;
      r_pc[i_wr_ptr]   <= i_line_pc;
    end
  end

  // Word enables start out clear
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < LINE_DEPTH; i++) begin
        r_en[i] <= '0;
      end
    end else if (i_wr_en) begin
      r_en[i_wr_ptr] <= i_line_en;
    end
  end

  // ====================
  // Read ports
  // ====================
  assign o_head_data = r_data[i_head_ptr];
  assign o_head_pc   = r_pc[i_head_ptr];
  assign o_head_en   = r_en[i_head_ptr];

  assign o_next_data = r_data[i_next_ptr];  // Line after the head
  assign o_next_pc   = r_pc[i_next_ptr];
  assign o_next_en   = r_en[i_next_ptr];

endmodule

// File: queue/ib_queue_ctrl.sv
`timescale 1ns/100ps

module ib_queue_ctrl #(
  parameter int LINE_DEPTH = ib_pkg::LINE_DEPTH
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_flush_valid,
  input  logic                          i_inst_valid,
  input  logic                          i_disp_fire,
  input  ib_pkg::disp_cnt_t             i_adv_cnt,
  input  ib_pkg::word_idx_t             i_head_offset,
  output logic                          o_inst_ready,
  output logic                          o_wr_en,
  output logic [$clog2(LINE_DEPTH)-1:0] o_wr_ptr,
  output logic [$clog2(LINE_DEPTH)-1:0] o_head_ptr,
  output logic [$clog2(LINE_DEPTH)-1:0] o_next_ptr,
  output logic                          o_head_held,
  output logic                          o_next_held,
  output ib_pkg::word_idx_t             o_cursor
);
  import ib_pkg::*;

  localparam int PTR_W = $clog2(LINE_DEPTH);
  localparam int CNT_W = $clog2(LINE_DEPTH + 1);
  localparam int POS_W = $bits(word_idx_t) + 1;

  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  word_idx_t        r_cursor;

  word_idx_t        w_start;
  logic [POS_W-1:0] w_end_pos;
  logic             w_retire;
  word_idx_t        w_cursor_nxt;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(LINE_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign o_inst_ready = (r_count < CNT_W'(LINE_DEPTH));
  assign o_wr_en      = i_inst_valid & o_inst_ready & ~i_flush_valid;

  // First word still owed from the head line
  assign w_start   = (i_head_offset > r_cursor) ? i_head_offset : r_cursor;
  assign w_end_pos = POS_W'(w_start) + POS_W'(i_adv_cnt);
  assign w_retire  = i_disp_fire & (w_end_pos >= POS_W'(WORDS_PER_LINE));

  assign w_cursor_nxt = word_idx_t'(w_end_pos);  // Wraps to the overflow on retire

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
      r_cursor <= '0;
    end else if (i_flush_valid) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
      r_cursor <= '0;
    end else begin
      if (o_wr_en) r_wr_ptr <= ptr_inc(r_wr_ptr);
      if (w_retire) r_rd_ptr <= ptr_inc(r_rd_ptr);
      if (i_disp_fire) r_cursor <= w_cursor_nxt;
      case ({o_wr_en, w_retire})
        2'b10:   r_count <= r_count + CNT_W'(1);
        2'b01:   r_count <= r_count - CNT_W'(1);
        default: r_count <= r_count;  // Both or neither
      endcase
    end
  end

  assign o_wr_ptr    = r_wr_ptr;
  assign o_head_ptr  = r_rd_ptr;
  assign o_next_ptr  = ptr_inc(r_rd_ptr);
  assign o_head_held = (r_count != '0);
  assign o_next_held = (r_count > CNT_W'(1));
  assign o_cursor    = r_cursor;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ib -f list.f -o sim_ib

./obj_dir/sim_ib > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verif/ib_properties.sv
`timescale 1ns/100ps

module ib_properties #(
  parameter int DISP_SIZE = ib_pkg::DISP_SIZE
) (
  input logic                 i_clk,
  input logic                 i_reset_n,
  input logic                 i_flush_valid,
  input logic                 i_inst_valid,
  input logic                 i_inst_ready,
  input logic                 i_disp_ready,
  input logic                 i_disp_valid,
  input logic [DISP_SIZE-1:0] i_disp_mask,
  input ib_pkg::inst_t        i_disp_inst [DISP_SIZE],
  input ib_pkg::pc_t          i_disp_pc   [DISP_SIZE],
  input logic                 i_disp_has_br,
  input ib_pkg::disp_cnt_t    i_ld_cnt,
  input ib_pkg::disp_cnt_t    i_st_cnt
);

  logic [DISP_SIZE*64-1:0] w_slots;  // Instructions and PCs side by side
  logic                    w_held;

  always_comb begin
    for (int k = 0; k < DISP_SIZE; k++) begin
      w_slots[64*k +: 64] = {i_disp_inst[k], i_disp_pc[k]};
    end
  end

  // Stalled with no line write and no flush
  assign w_held = i_disp_valid & ~i_disp_ready & ~i_flush_valid & ~(i_inst_valid & i_inst_ready);

  // Queue is empty one cycle after a flush
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
                   i_flush_valid |=> (!i_disp_valid && i_inst_ready))
    else $error("Buffer not empty after flush");

  assert property (@(posedge i_clk)
                   (!i_reset_n || $rose(i_reset_n)) |-> (!i_disp_valid && i_inst_ready))
    else $error("Buffer not idle out of reset");

  assert property (@(posedge i_clk) disable iff (!i_reset_n)
                   w_held |=> ($stable(i_disp_mask) && $stable(w_slots) &&
                               $stable(i_disp_has_br) && $stable({i_ld_cnt, i_st_cnt})))
    else $error("Dispatch outputs changed under back-pressure");

endmodule

bind ib_top ib_properties #(.DISP_SIZE(DISP_SIZE)) u_props (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_flush_valid (i_flush_valid),
  .i_inst_valid  (i_inst_valid),
  .i_inst_ready  (o_inst_ready),
  .i_disp_ready  (i_disp_ready),
  .i_disp_valid  (o_disp_valid),
  .i_disp_mask   (o_disp_mask),
  .i_disp_inst   (o_disp_inst),
  .i_disp_pc     (o_disp_pc),
  .i_disp_has_br (o_disp_has_br),
  .i_ld_cnt      (o_ld_cnt),
  .i_st_cnt      (o_st_cnt)
);

// File: verif/tb_ib.sv
`timescale 1ns/100ps

module tb_ib;
  import ib_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int TEST_CYCLES   = 4 + 6 + 10 + 8 + 12 + 10;  // Budget per test, in cycles
  localparam int MARGIN_CYCLES = 20;
  localparam logic [31:0] LFSR_POLY = 32'hA3000000;

  localparam logic [6:0] OPC_OP   = 7'b0110011;
  localparam logic [6:0] OPC_LUI  = 7'b0110111;
  localparam logic [6:0] OPC_LD   = 7'b0000011;
  localparam logic [6:0] OPC_ST   = 7'b0100011;
  localparam logic [6:0] OPC_BR   = 7'b1100011;
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_SYS  = 7'b1110011;
  localparam logic [6:0] OPC_BAD  = 7'b1111111;  // Unused major opcode
  localparam logic [6:0] OPC_ZERO = 7'b0000000;  // Low bits not 11

  logic                 clk;
  logic                 reset_n;
  logic                 flush_valid;
  logic                 inst_valid;
  logic                 inst_ready;
  pc_t                  inst_pc;
  line_data_t           inst_in;
  word_en_t             inst_en;
  logic                 disp_valid;
  logic                 disp_ready;
  logic [DISP_SIZE-1:0] disp_mask;
  inst_t                disp_inst [DISP_SIZE];
  pc_t                  disp_pc   [DISP_SIZE];
  inst_cat_t            disp_cat  [DISP_SIZE];
  logic                 disp_has_br;
  disp_cnt_t            ld_cnt;
  disp_cnt_t            st_cnt;
  logic [31:0]          lfsr_state = 32'h5759;

  ib_top #(.LINE_DEPTH(LINE_DEPTH), .DISP_SIZE(DISP_SIZE)) UUT (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_flush_valid (flush_valid),
    .i_inst_valid  (inst_valid),
    .o_inst_ready  (inst_ready),
    .i_inst_pc     (inst_pc),
    .i_inst_in     (inst_in),
    .i_inst_en     (inst_en),
    .o_disp_valid  (disp_valid),
    .i_disp_ready  (disp_ready),
    .o_disp_mask   (disp_mask),
    .o_disp_inst   (disp_inst),
    .o_disp_pc     (disp_pc),
    .o_disp_cat    (disp_cat),
    .o_disp_has_br (disp_has_br),
    .o_ld_cnt      (ld_cnt),
    .o_st_cnt      (st_cnt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // Checks
  // ====================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic check_cnt(input disp_cnt_t got, input disp_cnt_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_pc(input pc_t got, input pc_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_inst(input inst_t got, input inst_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_cat(input inst_cat_t got, input inst_cat_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("** Error @ %0t: %s is %s, expected %s", $time, what,
                          got.name(), exp.name()));
  endtask

  // Group size and summary flags; slots past n must read as zero
  task automatic expect_group(input int n, input logic br, input disp_cnt_t ld,
                              input disp_cnt_t st);
    check_bit(disp_valid, n > 0, "o_disp_valid");
    for (int k = 0; k < DISP_SIZE; k++) begin
      check_bit(disp_mask[k], k < n, $sformatf("o_disp_mask[%0d]", k));
      if (k >= n) check_inst(disp_inst[k], '0, $sformatf("o_disp_inst[%0d]", k));
    end
    check_bit(disp_has_br, br, "o_disp_has_br");
    check_cnt(ld_cnt, ld, "o_ld_cnt");
    check_cnt(st_cnt, st, "o_st_cnt");
  endtask

  task automatic expect_slot(input int k, input inst_t inst, input pc_t pc, input inst_cat_t cat);
    check_inst(disp_inst[k], inst, $sformatf("o_disp_inst[%0d]", k));
    check_pc(disp_pc[k], pc, $sformatf("o_disp_pc[%0d]", k));
    check_cat(disp_cat[k], cat, $sformatf("o_disp_cat[%0d]", k));
  endtask

  // ====================
  // Stimulus helpers
  // ====================
  function automatic logic lfsr_bit();
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_POLY) : (lfsr_state >> 1);
    return lfsr_state[0];
  endfunction

  // Random register and immediate fields above the opcode
  function automatic inst_t make_inst(input logic [6:0] opcode);
    inst_t inst;
    inst[6:0] = opcode;
    for (int i = 7; i < 32; i++) begin
      inst[i] = lfsr_bit();
    end
    return inst;
  endfunction

  function automatic line_data_t make_line(input logic [6:0] op0, input logic [6:0] op1,
                                           input logic [6:0] op2, input logic [6:0] op3);
    line_data_t line;
    line[31:0]   = make_inst(op0);
    line[63:32]  = make_inst(op1);
    line[95:64]  = make_inst(op2);
    line[127:96] = make_inst(op3);
    return line;
  endfunction

  function automatic inst_t word_of(input line_data_t line, input int idx);
    return line[32*idx +: 32];
  endfunction

  // All stimulus tasks start and end on a falling edge
  task automatic push_line(input pc_t pc, input line_data_t line, input word_en_t en);
    while (!inst_ready) @(negedge clk);
    inst_valid = 1'b1;
    inst_pc    = pc;
    inst_in    = line;
    inst_en    = en;
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic take_group();
    check_bit(disp_valid, 1'b1, "o_disp_valid before taking a group");
    disp_ready = 1'b1;
    @(negedge clk);
    disp_ready = 1'b0;
  endtask

  task automatic flush_buffer();
    flush_valid = 1'b1;
    #(CLK_PERIOD / 10);
    check_bit(disp_valid, 1'b0, "o_disp_valid during flush");
    @(negedge clk);
    flush_valid = 1'b0;
    check_bit(inst_ready, 1'b1, "o_inst_ready after flush");
    expect_group(0, 1'b0, 2'd0, 2'd0);
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic reset_values();
    check_bit(disp_valid, 1'b0, "o_disp_valid after reset");
    check_bit(inst_ready, 1'b1, "o_inst_ready after reset");
    check_cnt(ld_cnt, 2'd0, "o_ld_cnt after reset");
    check_cnt(st_cnt, 2'd0, "o_st_cnt after reset");
  endtask

  task automatic arith_pairs();
    line_data_t a;
    a = make_line(OPC_OP, OPC_LUI, OPC_OP, OPC_OP);
    push_line(32'h1000, a, 4'hF);
    expect_group(2, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(a, 0), 32'h1000, CAT_ARITH);
    expect_slot(1, word_of(a, 1), 32'h1004, CAT_ARITH);
    take_group();
    expect_group(2, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(a, 2), 32'h1008, CAT_ARITH);
    expect_slot(1, word_of(a, 3), 32'h100C, CAT_ARITH);
    take_group();
    expect_group(0, 1'b0, 2'd0, 2'd0);  // Line retired
  endtask

  task automatic cross_line_mix();
    line_data_t a;
    line_data_t b;
    a = make_line(OPC_LD, OPC_ST, OPC_BR, OPC_JAL);
    b = make_line(OPC_OP, OPC_ST, OPC_OP, OPC_SYS);
    push_line(32'h2000, a, 4'hF);
    push_line(32'h2010, b, 4'hF);
    expect_group(1, 1'b0, 2'd1, 2'd0);  // Store waits behind the load
    expect_slot(0, word_of(a, 0), 32'h2000, CAT_LD);
    take_group();
    expect_group(2, 1'b1, 2'd0, 2'd1);
    expect_slot(0, word_of(a, 1), 32'h2004, CAT_ST);
    expect_slot(1, word_of(a, 2), 32'h2008, CAT_BR);
    take_group();
    expect_group(3, 1'b1, 2'd0, 2'd1);  // Window spans both lines
    expect_slot(0, word_of(a, 3), 32'h200C, CAT_BR);
    expect_slot(1, word_of(b, 0), 32'h2010, CAT_ARITH);
    expect_slot(2, word_of(b, 1), 32'h2014, CAT_ST);
    take_group();
    expect_group(2, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(b, 2), 32'h2018, CAT_ARITH);
    expect_slot(1, word_of(b, 3), 32'h201C, CAT_CSU);
    take_group();
    expect_group(0, 1'b0, 2'd0, 2'd0);
  endtask

  task automatic unaligned_after_flush();
    line_data_t f;
    line_data_t u;
    f = make_line(OPC_LD, OPC_OP, OPC_OP, OPC_ST);
    push_line(32'h3000, f, 4'hF);
    expect_group(3, 1'b0, 2'd1, 2'd0);
    take_group();
    expect_group(1, 1'b0, 2'd0, 2'd1);  // Cursor now at word 3
    flush_buffer();
    u = make_line(OPC_OP, OPC_OP, OPC_SYS, OPC_OP);
    push_line(32'h3108, u, 4'hF);
    expect_group(2, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(u, 2), 32'h3108, CAT_CSU);
    expect_slot(1, word_of(u, 3), 32'h310C, CAT_ARITH);
    take_group();
    expect_group(0, 1'b0, 2'd0, 2'd0);
  endtask

  task automatic full_queue_backpressure();
    line_data_t l0;
    l0 = make_line(OPC_OP, OPC_OP, OPC_OP, OPC_LD);
    push_line(32'h4000, l0, 4'hF);
    for (int i = 1; i < LINE_DEPTH; i++) begin
      push_line(pc_t'(32'h4000 + 16 * i), make_line(OPC_OP, OPC_LD, OPC_ST, OPC_BR), 4'hF);
    end
    check_bit(inst_ready, 1'b0, "o_inst_ready with full queue");
    // One more line is offered and must not get in
    inst_valid = 1'b1;
    inst_pc    = 32'h4040;
    inst_in    = make_line(OPC_SYS, OPC_SYS, OPC_SYS, OPC_SYS);
    inst_en    = 4'hF;
    repeat (3) begin
      @(negedge clk);
      check_bit(inst_ready, 1'b0, "o_inst_ready under back-pressure");
      expect_group(2, 1'b0, 2'd0, 2'd0);
      expect_slot(0, word_of(l0, 0), 32'h4000, CAT_ARITH);
      expect_slot(1, word_of(l0, 1), 32'h4004, CAT_ARITH);
    end
    inst_valid = 1'b0;
    flush_buffer();
  endtask

  task automatic illegal_and_disabled();
    line_data_t il;
    line_data_t en;
    il = make_line(OPC_ZERO, OPC_BAD, OPC_OP, OPC_OP);
    push_line(32'h5000, il, 4'hF);
    expect_group(1, 1'b0, 2'd0, 2'd0);  // One illegal per group
    expect_slot(0, word_of(il, 0), 32'h5000, CAT_ILLEGAL);
    take_group();
    expect_group(3, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(il, 1), 32'h5004, CAT_ILLEGAL);
    expect_slot(1, word_of(il, 2), 32'h5008, CAT_ARITH);
    expect_slot(2, word_of(il, 3), 32'h500C, CAT_ARITH);
    take_group();
    expect_group(0, 1'b0, 2'd0, 2'd0);
    en = make_line(OPC_OP, OPC_LD, OPC_ST, OPC_OP);
    push_line(32'h5010, en, 4'b1101);   // Word 1 disabled
    expect_group(1, 1'b0, 2'd0, 2'd0);
    expect_slot(0, word_of(en, 0), 32'h5010, CAT_ARITH);
    take_group();
    expect_group(0, 1'b0, 2'd0, 2'd0);
    flush_buffer();
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    clk         = 1'b0;
    reset_n     = 1'b0;
    flush_valid = 1'b0;
    inst_valid  = 1'b0;
    inst_pc     = '0;
    inst_in     = '0;
    inst_en     = '0;
    disp_ready  = 1'b0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    reset_values();
    arith_pairs();
    cross_line_mix();
    unaligned_after_flush();
    full_queue_backpressure();
    illegal_and_disabled();
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #((3 + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    abort_run("Timeout: the tests did not complete within the watchdog limit");
  end

endmodule
